// File: Bender.yml
package:
  name: sdram_subsystem

sources:
  - sdram_pkg.sv
  - sdram_req_if.sv
  - cpu_bus_adapter.sv
  - sdram_sequencer.sv
  - sdram_cmd_drive.sv
  - sdram_read_capture.sv
  - sdram_subsystem_top.sv
  - target: test
    files:
      - tb_sdram_model.sv
      - tb_sdram_subsystem.sv

// File: cpu_bus_adapter.sv
`timescale 1ns/1ps

module cpu_bus_adapter (
    input  logic                         i_sysclk,
    input  logic                         i_arst,
    input  logic                         i_cpuclk,  // CPU phase clock, sampled as a level
    input  logic                         i_cs,
    input  logic                         i_rwb,     // High for read, low for write
    input  logic [sdram_pkg::ADDR_W-1:0] i_addr,    // Byte address
    input  logic [7:0]                   i_data,
    output logic [7:0]                   o_data,
    sdram_req_if.requester               req
);

    typedef enum logic [1:0] {WAIT, ACCESS, READ_WAIT, WRITE_WAIT} state_e;

    state_e state;
    state_e next_state;

    logic [sdram_pkg::WADDR_W-1:0] r_waddr;
    logic [sdram_pkg::DQ_W-1:0]    r_wdata;
    logic [sdram_pkg::DM_W-1:0]    r_dm;
    logic                          r_lane;  // Address bit 0, picks the byte within the word

    always_ff @(posedge i_sysclk) begin
        if (i_arst) begin
            state <= WAIT;
        end else begin
            state <= next_state;
        end
    end

    // The request fields follow the bus until a transfer is under way, then freeze
    // so that address, data and mask stay put while we or re is held
    always_ff @(posedge i_sysclk) begin
        if (state == WAIT || state == ACCESS) begin
            r_waddr <= i_addr[sdram_pkg::ADDR_W-1:1];
            r_lane  <= i_addr[0];
            r_wdata <= i_addr[0] ? {i_data, 8'h00} : {8'h00, i_data};  // Steer onto the lane
            r_dm    <= i_addr[0] ? 2'b01 : 2'b10;                      // Mask the other lane
        end
        if (state == READ_WAIT && req.rd_valid) begin
            o_data <= r_lane ? req.rdata[15:8] : req.rdata[7:0];
        end
    end

    always_comb begin
        next_state = state;
        unique case (state)
            WAIT: begin
                if (i_cs && i_cpuclk) begin
                    next_state = ACCESS;  // CPU cycle starts on the high phase
                end
            end
            ACCESS: begin
                if (!i_cs) begin
                    next_state = WAIT;
                end else if (i_rwb) begin
                    if (req.rd_ack) begin
                        next_state = READ_WAIT;
                    end
                end else if (!i_cpuclk) begin
                    // Write data is only settled once the phase clock has dropped
                    next_state = WRITE_WAIT;
                end
            end
            WRITE_WAIT: begin
                if (req.wr_ack) begin
                    next_state = WAIT;
                end
            end
            READ_WAIT: begin
                // Data normally lands well inside the high phase
                if (!i_cpuclk) begin
                    next_state = WAIT;
                end
            end
        endcase
    end

    assign req.re    = (state == ACCESS) && i_cs && i_rwb;  // Reads go out straight away
    assign req.we    = (state == WRITE_WAIT);
    assign req.waddr = r_waddr;
    assign req.wdata = r_wdata;
    assign req.dm    = r_dm;

    // Sequencer latches the request on accept, so we must not drop before the ack
    a_we_held : assert property (
        @(posedge i_sysclk) disable iff (i_arst)
        (req.we && !req.wr_ack) |=> req.we
    );

endmodule

// File: sdram_cmd_drive.sv
`timescale 1ns/1ps

module sdram_cmd_drive (
    input  logic                          i_sysclk,
    input  logic                          i_arst,
    input  sdram_pkg::sdram_cmd_e         i_cmd,
    input  logic [sdram_pkg::WADDR_W-1:0] i_waddr,
    input  logic [sdram_pkg::DQ_W-1:0]    i_wdata,
    input  logic [sdram_pkg::DM_W-1:0]    i_dm,
    input  logic                          i_dq_oe,
    output logic                          o_sdr_cke,
    output logic                          o_sdr_n_cs,
    output logic                          o_sdr_n_ras,
    output logic                          o_sdr_n_cas,
    output logic                          o_sdr_n_we,
    output logic [sdram_pkg::BANK_W-1:0]  o_sdr_ba,
    output logic [sdram_pkg::ROW_W-1:0]   o_sdr_addr,
    output logic [sdram_pkg::DQ_W-1:0]    o_sdr_dq,
    output logic [sdram_pkg::DQ_W-1:0]    o_sdr_dq_oe,  // One enable per DQ pin
    output logic [sdram_pkg::DM_W-1:0]    o_sdr_dqm
);

    logic [sdram_pkg::ROW_W-1:0]  addr_next;
    logic [sdram_pkg::BANK_W-1:0] ba_next;

    always_comb begin
        addr_next = '0;
        ba_next   = '0;  // LOAD_MODE and PRECHARGE all want bank 0
        case (i_cmd)
            sdram_pkg::CMD_ACTIVE: begin
                addr_next = i_waddr[sdram_pkg::COL_W +: sdram_pkg::ROW_W];  // Row field
                ba_next   = i_waddr[sdram_pkg::WADDR_W-1 -: sdram_pkg::BANK_W];
            end
            sdram_pkg::CMD_READ, sdram_pkg::CMD_WRITE: begin
                addr_next[sdram_pkg::COL_W-1:0] = i_waddr[sdram_pkg::COL_W-1:0];
                addr_next[sdram_pkg::AP_BIT]    = 1'b1;  // Auto-precharge
                ba_next   = i_waddr[sdram_pkg::WADDR_W-1 -: sdram_pkg::BANK_W];
            end
            sdram_pkg::CMD_PRECHARGE: addr_next[sdram_pkg::AP_BIT] = 1'b1;  // All banks
            sdram_pkg::CMD_LOAD_MODE: addr_next = sdram_pkg::MODE_WORD;
            default: ;
        endcase
    end

    // Control pins sit at NOP with DQ released while reset is high
    always_ff @(posedge i_sysclk) begin
        if (i_arst) begin
            o_sdr_cke <= 1'b0;
            {o_sdr_n_cs, o_sdr_n_ras, o_sdr_n_cas, o_sdr_n_we} <= sdram_pkg::CMD_NOP;
            o_sdr_dq_oe <= '0;
        end else begin
            o_sdr_cke <= 1'b1;
            {o_sdr_n_cs, o_sdr_n_ras, o_sdr_n_cas, o_sdr_n_we} <= i_cmd;
            o_sdr_dq_oe <= {sdram_pkg::DQ_W{i_dq_oe}};
        end
    end

    always_ff @(posedge i_sysclk) begin
        o_sdr_ba   <= ba_next;
        o_sdr_addr <= addr_next;
        o_sdr_dq   <= i_wdata;
        o_sdr_dqm  <= i_dm;
    end

endmodule

// File: sdram_pkg.sv
package sdram_pkg;

    // CPU side geometry
    localparam int ADDR_W  = 25;  // Byte address from the CPU bus
    localparam int WADDR_W = 24;  // Word address, byte address shifted right by one

    // Word address split, high to low: bank, row, column
    localparam int BANK_W = 2;
    localparam int ROW_W  = 13;
    localparam int COL_W  = 9;
    localparam int AP_BIT = 10;   // A10 selects auto-precharge or all-bank precharge

    localparam int DQ_W = 16;
    localparam int DM_W = 2;

    // SDRAM timing, all in i_sysclk cycles
    localparam int CAS_LAT = 2;
    localparam int T_RCD   = 2;   // ACTIVE to READ or WRITE
    localparam int T_RP    = 2;   // Precharge period
    localparam int T_RFC   = 7;   // REFRESH to next command
    localparam int T_WR    = 2;   // Write recovery before auto-precharge starts

    localparam int INIT_WAIT    = 200;  // Far below the datasheet figure so simulation stays short
    localparam int REF_INTERVAL = 780;

    // Burst length 1, sequential, CAS latency 2, programmed burst writes
    localparam logic [ROW_W-1:0] MODE_WORD = 13'b000_0_00_010_0_000;

    // Counter sizes for the sequencer
    localparam int GAP_W = $clog2(INIT_WAIT);
    localparam int REF_W = $clog2(REF_INTERVAL);

    typedef logic [GAP_W-1:0] gap_t;
    typedef logic [REF_W-1:0] ref_t;

    // Bit order is {n_cs, n_ras, n_cas, n_we}
    typedef enum logic [3:0] {
        CMD_NOP       = 4'b0111,
        CMD_ACTIVE    = 4'b0011,
        CMD_READ      = 4'b0101,
        CMD_WRITE     = 4'b0100,
        CMD_PRECHARGE = 4'b0010,
        CMD_REFRESH   = 4'b0001,
        CMD_LOAD_MODE = 4'b0000
    } sdram_cmd_e;

endpackage

// File: sdram_read_capture.sv
`timescale 1ns/1ps

module sdram_read_capture (
    input  logic                       i_sysclk,
    input  logic                       i_arst,
    input  logic                       i_rd_launch,  // Same cycle the READ leaves the sequencer
    input  logic [sdram_pkg::DQ_W-1:0] i_sdr_dq,
    sdram_req_if.returner              ret
);

    // One stage for the pin register plus CAS_LAT stages inside the SDRAM
    logic [sdram_pkg::CAS_LAT:0] launch_sr;

    always_ff @(posedge i_sysclk) begin
        if (i_arst) begin
            launch_sr    <= '0;
            ret.rd_valid <= 1'b0;
        end else begin
            launch_sr    <= {launch_sr[sdram_pkg::CAS_LAT-1:0], i_rd_launch};
            ret.rd_valid <= launch_sr[sdram_pkg::CAS_LAT];
        end
    end

    // Each launch travels alone, so back to back reads can overlap
    always_ff @(posedge i_sysclk) begin
        if (launch_sr[sdram_pkg::CAS_LAT]) begin
            ret.rdata <= i_sdr_dq;
        end
    end

    // A capture that misses the SDRAM's data window picks up a floating bus
    a_rd_data_known : assert property (
        @(posedge i_sysclk) disable iff (i_arst)
        ret.rd_valid |-> !$isunknown(ret.rdata)
    );

endmodule

// File: sdram_req_if.sv
`timescale 1ns/1ps

interface sdram_req_if;

    logic                          we;      // Held until wr_ack
    logic                          re;      // Held until rd_ack
    logic [sdram_pkg::WADDR_W-1:0] waddr;
    logic [sdram_pkg::DQ_W-1:0]    wdata;
    logic [sdram_pkg::DM_W-1:0]    dm;      // A set bit masks that byte
    logic                          wr_ack;  // One cycle pulse with the WRITE command
    logic                          rd_ack;  // One cycle pulse with the READ command
    logic [sdram_pkg::DQ_W-1:0]    rdata;
    logic                          rd_valid;

    modport requester (
        output we, re, waddr, wdata, dm,
        input  wr_ack, rd_ack, rdata, rd_valid
    );

    modport server (input we, re, waddr, wdata, dm, output wr_ack, rd_ack);

    // Read capture only touches the return path
    modport returner (output rdata, rd_valid);

endinterface

// File: sdram_sequencer.sv
`timescale 1ns/1ps

module sdram_sequencer (
    input  logic                          i_sysclk,
    input  logic                          i_arst,
    sdram_req_if.server                   req,
    output sdram_pkg::sdram_cmd_e         o_cmd,
    output logic [sdram_pkg::WADDR_W-1:0] o_cmd_waddr,
    output logic [sdram_pkg::DQ_W-1:0]    o_cmd_wdata,
    output logic [sdram_pkg::DM_W-1:0]    o_cmd_dm,
    output logic                          o_dq_oe,
    output logic                          o_rd_launch,  // Pulse alongside every READ
    output logic                          o_init_done
);

    typedef enum logic [2:0] {S_POWERUP, S_INIT_REF, S_INIT_MODE, S_IDLE, S_RW} state_e;

    state_e              state;
    sdram_pkg::gap_t     gap;       // Shared down counter for every timing gap
    sdram_pkg::ref_t     ref_cnt;   // Free running refresh timer
    logic                ref_pend;
    logic                init_ref;  // Set once the first init REFRESH has gone out
    logic                r_we;      // Direction of the accepted request

    // Refresh timer runs regardless of what the command FSM is doing
    always_ff @(posedge i_sysclk) begin
        if (i_arst) begin
            ref_cnt  <= '0;
            ref_pend <= 1'b0;
        end else begin
            if (ref_cnt == sdram_pkg::ref_t'(sdram_pkg::REF_INTERVAL - 1)) begin
                ref_cnt  <= '0;
                ref_pend <= 1'b1;
            end else begin
                ref_cnt <= ref_cnt + 1'b1;
            end
            if (state == S_IDLE && gap == '0 && ref_pend) begin
                ref_pend <= 1'b0;  // Served this cycle
            end
        end
    end

    // A gap of N-1 puts the next command exactly N cycles after this one
    always_ff @(posedge i_sysclk) begin
        if (i_arst) begin
            state       <= S_POWERUP;
            gap         <= sdram_pkg::gap_t'(sdram_pkg::INIT_WAIT - 1);
            init_ref    <= 1'b0;
            o_init_done <= 1'b0;
            o_cmd       <= sdram_pkg::CMD_NOP;
            o_dq_oe     <= 1'b0;
            o_rd_launch <= 1'b0;
            req.wr_ack  <= 1'b0;
            req.rd_ack  <= 1'b0;
        end else begin
            o_cmd       <= sdram_pkg::CMD_NOP;  // Default every cycle, commands are single pulses
            o_dq_oe     <= 1'b0;
            o_rd_launch <= 1'b0;
            req.wr_ack  <= 1'b0;
            req.rd_ack  <= 1'b0;
            if (gap != '0) begin
                gap <= gap - 1'b1;
            end else begin
                unique case (state)
                    S_POWERUP: begin
                        o_cmd <= sdram_pkg::CMD_PRECHARGE;  // All banks, A10 set by the driver
                        gap   <= sdram_pkg::gap_t'(sdram_pkg::T_RP - 1);
                        state <= S_INIT_REF;
                    end
                    S_INIT_REF: begin
                        o_cmd    <= sdram_pkg::CMD_REFRESH;
                        gap      <= sdram_pkg::gap_t'(sdram_pkg::T_RFC);
                        init_ref <= 1'b1;
                        if (init_ref) begin
                            state <= S_INIT_MODE;  // Second of the two init refreshes
                        end
                    end
                    S_INIT_MODE: begin
                        o_cmd <= sdram_pkg::CMD_LOAD_MODE;
                        gap   <= sdram_pkg::gap_t'(sdram_pkg::T_RP - 1);
                        state <= S_IDLE;
                    end
                    S_IDLE: begin
                        o_init_done <= 1'b1;  // First idle cycle is T_RP after LOAD_MODE
                        if (ref_pend) begin
                            o_cmd <= sdram_pkg::CMD_REFRESH;
                            gap   <= sdram_pkg::gap_t'(sdram_pkg::T_RFC);
                        end else if (o_init_done && (req.we || req.re)) begin
                            r_we        <= req.we;
                            o_cmd_waddr <= req.waddr;
                            o_cmd_wdata <= req.wdata;
                            o_cmd_dm    <= req.we ? req.dm : '0;  // Reads keep both lanes on
                            o_cmd       <= sdram_pkg::CMD_ACTIVE;
                            gap         <= sdram_pkg::gap_t'(sdram_pkg::T_RCD - 1);
                            state       <= S_RW;
                        end
                    end
                    S_RW: begin
                        // Both commands carry auto-precharge, so the bank closes by itself
                        o_cmd       <= r_we ? sdram_pkg::CMD_WRITE : sdram_pkg::CMD_READ;
                        o_dq_oe     <= r_we;
                        o_rd_launch <= !r_we;
                        req.wr_ack  <= r_we;
                        req.rd_ack  <= !r_we;
                        gap         <= r_we ?
                            sdram_pkg::gap_t'(sdram_pkg::T_WR + sdram_pkg::T_RP - 1) :
                            sdram_pkg::gap_t'(sdram_pkg::CAS_LAT + sdram_pkg::T_RP - 1);
                        state       <= S_IDLE;
                    end
                    default: state <= S_IDLE;
                endcase
            end
        end
    end

    a_one_dir : assert property (
        @(posedge i_sysclk) disable iff (i_arst) !(req.we && req.re)
    );

    // Init never opens a row, so an ACTIVE before init_done means a request slipped in
    a_no_early_active : assert property (
        @(posedge i_sysclk) disable iff (i_arst) (o_cmd == sdram_pkg::CMD_ACTIVE) |-> o_init_done
    );

endmodule

// File: sdram_subsystem_top.sv
`timescale 1ns/1ps

module sdram_subsystem_top (
    input  logic                         i_sysclk,
    input  logic                         i_arst,
    input  logic                         i_cpuclk,
    input  logic                         i_cs,
    input  logic                         i_rwb,
    input  logic [sdram_pkg::ADDR_W-1:0] i_addr,
    input  logic [7:0]                   i_data,
    output logic [7:0]                   o_data,
    output logic                         o_init_done,
    output logic                         o_sdr_cke,
    output logic                         o_sdr_n_cs,
    output logic                         o_sdr_n_ras,
    output logic                         o_sdr_n_cas,
    output logic                         o_sdr_n_we,
    output logic [sdram_pkg::BANK_W-1:0] o_sdr_ba,
    output logic [sdram_pkg::ROW_W-1:0]  o_sdr_addr,
    output logic [sdram_pkg::DQ_W-1:0]   o_sdr_dq,
    output logic [sdram_pkg::DQ_W-1:0]   o_sdr_dq_oe,
    output logic [sdram_pkg::DM_W-1:0]   o_sdr_dqm,
    input  logic [sdram_pkg::DQ_W-1:0]   i_sdr_dq
);

    sdram_req_if req_if ();

    // Sequencer to pin driver
    sdram_pkg::sdram_cmd_e         w_cmd;
    logic [sdram_pkg::WADDR_W-1:0] w_cmd_waddr;
    logic [sdram_pkg::DQ_W-1:0]    w_cmd_wdata;
    logic [sdram_pkg::DM_W-1:0]    w_cmd_dm;
    logic                          w_dq_oe;
    logic                          w_rd_launch;

    cpu_bus_adapter u_adapter (
        .i_sysclk, .i_arst, .i_cpuclk, .i_cs, .i_rwb, .i_addr, .i_data, .o_data,
        .req (req_if.requester)
    );

    sdram_sequencer u_sequencer (
        .i_sysclk, .i_arst, .req (req_if.server),
        .o_cmd (w_cmd), .o_cmd_waddr (w_cmd_waddr), .o_cmd_wdata (w_cmd_wdata),
        .o_cmd_dm (w_cmd_dm), .o_dq_oe (w_dq_oe), .o_rd_launch (w_rd_launch), .o_init_done
    );

    sdram_cmd_drive u_cmd_drive (
        .i_sysclk, .i_arst, .i_cmd (w_cmd), .i_waddr (w_cmd_waddr), .i_wdata (w_cmd_wdata),
        .i_dm (w_cmd_dm), .i_dq_oe (w_dq_oe), .o_sdr_cke, .o_sdr_n_cs, .o_sdr_n_ras,
        .o_sdr_n_cas, .o_sdr_n_we, .o_sdr_ba, .o_sdr_addr, .o_sdr_dq, .o_sdr_dq_oe, .o_sdr_dqm
    );

    sdram_read_capture u_read_capture (
        .i_sysclk, .i_arst, .i_rd_launch (w_rd_launch), .i_sdr_dq, .ret (req_if.returner)
    );

endmodule

// File: src.f
sdram_pkg.sv
sdram_req_if.sv
cpu_bus_adapter.sv
sdram_sequencer.sv
sdram_cmd_drive.sv
sdram_read_capture.sv
sdram_subsystem_top.sv
tb_sdram_model.sv
tb_sdram_subsystem.sv

// File: tb_sdram_model.sv
`timescale 1ns/1ps

module sdram_model (
    input  logic                         i_sysclk,
    input  logic                         i_arst,
    input  logic                         i_init_done,
    input  logic                         i_n_cs,
    input  logic                         i_n_ras,
    input  logic                         i_n_cas,
    input  logic                         i_n_we,
    input  logic [sdram_pkg::BANK_W-1:0] i_ba,
    input  logic [sdram_pkg::ROW_W-1:0]  i_addr,
    input  logic [sdram_pkg::DQ_W-1:0]   i_dq,     // Write data from the controller
    input  logic [sdram_pkg::DQ_W-1:0]   i_dq_oe,
    input  logic [sdram_pkg::DM_W-1:0]   i_dqm,
    output logic [sdram_pkg::DQ_W-1:0]   o_dq,     // Resolved bus seen by the controller
    output int                           o_ref_cnt,  // Periodic refreshes after init
    output logic                         o_error
);

    sdram_pkg::sdram_cmd_e        cmd;
    logic [sdram_pkg::DQ_W-1:0]   mem [logic [sdram_pkg::WADDR_W-1:0]];
    logic [sdram_pkg::ROW_W-1:0]  open_row [4];
    int                           act_cycle [4];
    logic [3:0]                   bank_open;
    int                           cycle = 0;
    int                           init_step;  // 0 idle, 1 precharged, 2 and 3 refreshed, 4 mode set
    logic [sdram_pkg::DQ_W-1:0]   rd_pipe [sdram_pkg::CAS_LAT];
    logic [sdram_pkg::WADDR_W-1:0] key;
    logic [sdram_pkg::DQ_W-1:0]   word;

    initial o_error = 1'b0;

    assign cmd  = sdram_pkg::sdram_cmd_e'({i_n_cs, i_n_ras, i_n_cas, i_n_we});
    assign key  = {i_ba, open_row[i_ba], i_addr[sdram_pkg::COL_W-1:0]};  // Row from the ACTIVE
    // Each pin carries the controller's bit when its own enable is set
    assign o_dq = (i_dq & i_dq_oe) | (rd_pipe[sdram_pkg::CAS_LAT-1] & ~i_dq_oe);

    // Words never written read back as a pattern of their full address
    function automatic logic [sdram_pkg::DQ_W-1:0] stored_word(input logic [23:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a[15:0] ^ {a[7:0], a[23:16]};
    endfunction

    task automatic report_error(input string why);
        $display("Fail at %0t: %s", $time, why);
        o_error <= 1'b1;
    endtask

    always @(posedge i_sysclk) begin
        for (int i = sdram_pkg::CAS_LAT - 1; i > 0; i--) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
        rd_pipe[0] <= 'x;  // Bus floats unless a read is in flight
        cycle      <= cycle + 1;
        if (i_arst) begin
            init_step <= 0;
            o_ref_cnt <= 0;
            bank_open <= '0;
        end else begin
            case (cmd)
                sdram_pkg::CMD_PRECHARGE: begin
                    a_init_pre : assert (!i_init_done && init_step == 0)
                        else report_error("PRECHARGE outside the start of the init sequence");
                    init_step <= 1;
                end
                sdram_pkg::CMD_REFRESH: begin
                    if (i_init_done) begin
                        o_ref_cnt <= o_ref_cnt + 1;
                    end else begin
                        a_init_ref : assert (init_step == 1 || init_step == 2)
                            else report_error("Init REFRESH out of order");
                        init_step <= init_step + 1;
                    end
                end
                sdram_pkg::CMD_LOAD_MODE: begin
                    a_init_mode : assert (init_step == 3 && i_addr == sdram_pkg::MODE_WORD)
                        else report_error("LOAD_MODE out of order or with a wrong mode word");
                    init_step <= 4;
                end
                sdram_pkg::CMD_ACTIVE: begin
                    open_row[i_ba]  <= i_addr;
                    act_cycle[i_ba] <= cycle;
                    bank_open[i_ba] <= 1'b1;
                end
                sdram_pkg::CMD_READ, sdram_pkg::CMD_WRITE: begin
                    a_rcd : assert (bank_open[i_ba] && cycle - act_cycle[i_ba] >= sdram_pkg::T_RCD)
                        else report_error("READ or WRITE to a closed bank or before T_RCD");
                    bank_open[i_ba] <= 1'b0;  // Auto-precharge
                    if (cmd == sdram_pkg::CMD_WRITE) begin
                        word = stored_word(key);
                        if (!i_dqm[0]) word[7:0] = i_dq[7:0];
                        if (!i_dqm[1]) word[15:8] = i_dq[15:8];
                        mem[key] = word;
                    end else begin
                        rd_pipe[0] <= stored_word(key);  // Reaches the bus CAS_LAT edges later
                    end
                end
                default: ;
            endcase
        end
    end

    a_rfc_gap : assert property (@(posedge i_sysclk) disable iff (i_arst)
        (cmd == sdram_pkg::CMD_REFRESH) |=> (cmd != sdram_pkg::CMD_ACTIVE) [*sdram_pkg::T_RFC]
    ) else report_error("ACTIVE within T_RFC of a REFRESH");

    a_no_early_rw : assert property (@(posedge i_sysclk) disable iff (i_arst)
        (cmd inside {sdram_pkg::CMD_ACTIVE, sdram_pkg::CMD_READ, sdram_pkg::CMD_WRITE})
        |-> i_init_done
    ) else report_error("Row or column command before init done");

    a_init_seq : assert property (@(posedge i_sysclk) disable iff (i_arst)
        $rose(i_init_done) |-> (init_step == 4)
    ) else report_error("Init done raised before the full init sequence");

endmodule

// File: tb_sdram_subsystem.sv
`timescale 1ns/1ps

module tb_sdram_subsystem;

    localparam int PHASE_CYCLES = 40;   // i_sysclk cycles per half of the CPU phase clock
    localparam int INIT_LIMIT   = 400;
    localparam int N_ACCESS     = 24;

    logic                         i_sysclk;
    logic                         i_arst;
    logic                         i_cpuclk;
    logic                         i_cs;
    logic                         i_rwb;
    logic [sdram_pkg::ADDR_W-1:0] i_addr;
    logic [7:0]                   i_data;
    logic [7:0]                   o_data;
    logic                         o_init_done;
    logic                         sdr_cke;
    logic                         sdr_n_cs;
    logic                         sdr_n_ras;
    logic                         sdr_n_cas;
    logic                         sdr_n_we;
    logic [sdram_pkg::BANK_W-1:0] sdr_ba;
    logic [sdram_pkg::ROW_W-1:0]  sdr_addr;
    logic [sdram_pkg::DQ_W-1:0]   sdr_dq_out;
    logic [sdram_pkg::DQ_W-1:0]   sdr_dq_oe;
    logic [sdram_pkg::DQ_W-1:0]   sdr_dq_in;
    logic [sdram_pkg::DM_W-1:0]   sdr_dqm;
    int                           ref_cnt;
    logic                         model_err;

    logic [7:0]                   scb [logic [sdram_pkg::ADDR_W-1:0]];  // Expected byte per address
    logic [sdram_pkg::ADDR_W-1:0] addrs [$];                            // Addresses written so far
    logic [sdram_pkg::ADDR_W-1:0] a;
    logic [7:0]                   d;
    int                           seed = 87762;
    int                           cycle = 0;
    int                           init_cycle;
    int                           elapsed;
    logic                         read_seen = 1'b0;  // o_data is defined after the first read

    sdram_subsystem_top UUT (
        .i_sysclk, .i_arst, .i_cpuclk, .i_cs, .i_rwb, .i_addr, .i_data, .o_data, .o_init_done,
        .o_sdr_cke (sdr_cke), .o_sdr_n_cs (sdr_n_cs), .o_sdr_n_ras (sdr_n_ras),
        .o_sdr_n_cas (sdr_n_cas), .o_sdr_n_we (sdr_n_we), .o_sdr_ba (sdr_ba),
        .o_sdr_addr (sdr_addr), .o_sdr_dq (sdr_dq_out), .o_sdr_dq_oe (sdr_dq_oe),
        .o_sdr_dqm (sdr_dqm), .i_sdr_dq (sdr_dq_in)
    );

    sdram_model u_model (
        .i_sysclk, .i_arst, .i_init_done (o_init_done), .i_n_cs (sdr_n_cs), .i_n_ras (sdr_n_ras),
        .i_n_cas (sdr_n_cas), .i_n_we (sdr_n_we), .i_ba (sdr_ba), .i_addr (sdr_addr),
        .i_dq (sdr_dq_out), .i_dq_oe (sdr_dq_oe), .i_dqm (sdr_dqm), .o_dq (sdr_dq_in),
        .o_ref_cnt (ref_cnt), .o_error (model_err)
    );

    initial begin
        i_sysclk = 1'b0;
        forever #10 i_sysclk = ~i_sysclk;
    end

    always @(posedge i_sysclk) cycle <= cycle + 1;

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    always @(posedge model_err) fail_stop("The SDRAM model saw a command protocol violation");

    task automatic wait_init();
        int n = 0;
        while (!o_init_done) begin
            @(posedge i_sysclk);
            n++;
            if (n > INIT_LIMIT) fail_stop("o_init_done did not rise after reset");
        end
    endtask

    // High phase with the bus driven, low phase, then chip select drops
    task automatic bus_cycle(input logic rd, input logic [sdram_pkg::ADDR_W-1:0] addr,
                             input logic [7:0] wbyte);
        @(posedge i_sysclk);
        i_cs     <= 1'b1;
        i_cpuclk <= 1'b1;
        i_rwb    <= rd;
        i_addr   <= addr;
        i_data   <= rd ? 8'h00 : wbyte;
        repeat (PHASE_CYCLES) @(posedge i_sysclk);
        i_cpuclk <= 1'b0;  // Adapter issues the write once it sees this
        repeat (PHASE_CYCLES) @(posedge i_sysclk);
        if (rd) begin
            a_rd_data : assert (o_data == scb[addr]) else fail_stop($sformatf(
                "Fail at %0t: o_data 0x%02h, expected 0x%02h at address 0x%07h",
                $time, o_data, scb[addr], addr));
            read_seen = 1'b1;
        end else begin
            scb[addr] = wbyte;
        end
        i_cs <= 1'b0;
    endtask

    // Read data may only move while the CPU is reading
    a_data_hold : assert property (@(posedge i_sysclk) disable iff (i_arst || !read_seen)
        !i_cs |=> $stable(o_data)
    ) else fail_stop($sformatf("Fail at %0t: o_data changed while chip select was low", $time));

    // The SDRAM needs its clock enabled from the first cycle out of reset on
    a_cke_high : assert property (@(posedge i_sysclk) disable iff (i_arst)
        !$past(i_arst) |-> sdr_cke
    ) else fail_stop($sformatf("Fail at %0t: CKE is low after reset was released", $time));

    initial begin
        i_arst   <= 1'b1;
        i_cpuclk <= 1'b0;
        i_cs     <= 1'b0;
        i_rwb    <= 1'b1;
        i_addr   <= '0;
        i_data   <= '0;
        repeat (16) @(posedge i_sysclk);
        i_arst <= 1'b0;
        wait_init();
        init_cycle = cycle;
        // Each random write is followed by a read of some address written so far
        for (int i = 0; i < N_ACCESS; i++) begin
            a = $random(seed);
            d = $random(seed);
            bus_cycle(1'b0, a, d);
            addrs.push_back(a);
            bus_cycle(1'b1, addrs[$unsigned($random(seed)) % addrs.size()], 8'h00);
            repeat ($unsigned($random(seed)) % 8) @(posedge i_sysclk);  // Idle with cs low
        end
        // The odd byte of one word gets the inverse of the even byte
        a = {$random(seed), 1'b0};
        d = $random(seed);
        bus_cycle(1'b0, a, d);
        bus_cycle(1'b0, {a[sdram_pkg::ADDR_W-1:1], 1'b1}, ~d);
        bus_cycle(1'b1, a, 8'h00);
        bus_cycle(1'b1, {a[sdram_pkg::ADDR_W-1:1], 1'b1}, 8'h00);
        elapsed = cycle - init_cycle;
        if (ref_cnt >= elapsed / sdram_pkg::REF_INTERVAL - 1) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            fail_stop($sformatf("Fail at %0t: only %0d refreshes were issued in %0d cycles",
                                $time, ref_cnt, elapsed));
        end
    end

endmodule
